// File: design/panel_pkg.sv
// **********************************************************************
// Shared widths, register map, PWM and debounce constants and types.
// **********************************************************************
package panel_pkg;

    // AXI4-Lite channel fields.
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;
    typedef logic [1:0]  axil_resp_t;

    // Backlight duty value, 0 to 1000 and beyond.
    typedef logic [9:0] brightness_t;

    typedef logic [10:0] debounce_count_t;

    typedef enum logic {
        STABLE,
        SETTLING
    } debounce_state_t;

    // 50 MHz / 250 / 1000 gives a 200 Hz backlight.
    localparam int PWM_PRESCALE = 250;
    localparam int PWM_MAX      = 1000;

    // About 20 us of stable level before a new button level counts.
    localparam int DEBOUNCE_CYCLES = 1024;

    // Register map.
    localparam axil_addr_t CONTROL_ADDR = 8'h00;
    localparam axil_addr_t STATUS_ADDR  = 8'h04;

    // Control register fields above the brightness.
    localparam int CTRL_ENABLE_BIT = 10;
    localparam int CTRL_ACK_BIT    = 11;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage

// File: design/panel_ctrl_if.sv
// **********************************************************************
// Control and status signals between the register block and peripherals.
// **********************************************************************
interface panel_ctrl_if;
    import panel_pkg::*;

    brightness_t brightness;
    logic        brightness_enable;
    logic        button_ack;
    // Latched home button level, as seen by the host.
    logic        button_state;

    modport regs (
        output brightness,
        output brightness_enable,
        output button_ack,
        input  button_state
    );

    modport pwm (
        input  brightness,
        input  brightness_enable
    );

    modport button (
        input  button_ack,
        output button_state
    );

endinterface

// File: design/axil_panel_regs.sv
// **********************************************************************
// AXI4-Lite slave with the control register and the status readback.
// **********************************************************************
module axil_panel_regs (
    input  logic                  clock_50,
    input  logic                  reset_n,
    // Write address channel.
    input  panel_pkg::axil_addr_t s_axil_awaddr,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    // Write data channel.
    input  panel_pkg::axil_data_t s_axil_wdata,
    input  panel_pkg::axil_strb_t s_axil_wstrb,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    // Write response channel.
    output panel_pkg::axil_resp_t s_axil_bresp,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    // Read address channel.
    input  panel_pkg::axil_addr_t s_axil_araddr,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    // Read data channel.
    output panel_pkg::axil_data_t s_axil_rdata,
    output panel_pkg::axil_resp_t s_axil_rresp,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    panel_ctrl_if.regs            ctrl
);
    import panel_pkg::*;

    brightness_t brightness_q;
    logic        enable_q;
    logic        ack_q;
    axil_data_t  ctrl_word;
    axil_data_t  ctrl_next;
    axil_data_t  status_word;
    logic        write_accept;
    logic        read_accept;
    logic        write_hit;

    // Address and data are taken together, one response in flight.
    assign write_accept   = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign read_accept    = s_axil_arvalid && !s_axil_rvalid;
    assign s_axil_awready = write_accept;
    assign s_axil_wready  = write_accept;
    assign s_axil_arready = read_accept;
    assign write_hit      = (s_axil_awaddr == CONTROL_ADDR);

    // Control register as the host sees it; unused bits read as zero.
    always_comb begin
        ctrl_word = '0;
        ctrl_word[$bits(brightness_t)-1:0] = brightness_q;
        ctrl_word[CTRL_ENABLE_BIT] = enable_q;
        ctrl_word[CTRL_ACK_BIT] = ack_q;
    end

    // Merge strobed bytes over the current value.
    always_comb begin
        ctrl_next = ctrl_word;
        for (int i = 0; i < $bits(axil_strb_t); i++) begin
            if (s_axil_wstrb[i]) begin
                ctrl_next[8*i +: 8] = s_axil_wdata[8*i +: 8];
            end
        end
    end

    assign status_word = axil_data_t'(ctrl.button_state);

    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            s_axil_bvalid <= 1'b0;
            brightness_q  <= '0;
            enable_q      <= 1'b0;
            ack_q         <= 1'b0;
        end else if (write_accept) begin
            s_axil_bvalid <= 1'b1;
            if (write_hit) begin
                brightness_q <= ctrl_next[$bits(brightness_t)-1:0];
                enable_q     <= ctrl_next[CTRL_ENABLE_BIT];
                ack_q        <= ctrl_next[CTRL_ACK_BIT];
            end
        end else if (s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock_50) begin
        if (write_accept) begin
            s_axil_bresp <= write_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            s_axil_rvalid <= 1'b0;
        end else if (read_accept) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    // Read data is captured at acceptance and held until rready.
    always_ff @(posedge clock_50) begin
        if (read_accept) begin
            case (s_axil_araddr)
                CONTROL_ADDR: begin
                    s_axil_rdata <= ctrl_word;
                    s_axil_rresp <= RESP_OKAY;
                end
                STATUS_ADDR: begin
                    s_axil_rdata <= status_word;
                    s_axil_rresp <= RESP_OKAY;
                end
                default: begin
                    s_axil_rdata <= '0;
                    s_axil_rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

    assign ctrl.brightness        = brightness_q;
    assign ctrl.brightness_enable = enable_q;
    assign ctrl.button_ack        = ack_q;

endmodule

// File: design/backlight_pwm.sv
// **********************************************************************
// Backlight prescaler, duty counter and registered PWM output.
// **********************************************************************
module backlight_pwm (
    input  logic       clock_50,
    input  logic       reset_n,
    panel_ctrl_if.pwm  ctrl,
    output logic       backlight
);
    import panel_pkg::*;

    typedef logic [$clog2(PWM_PRESCALE)-1:0] prescale_count_t;

    prescale_count_t prescale_count;
    logic            step_tick;
    brightness_t     duty_count;
    brightness_t     effective;

    // One step pulse every PWM_PRESCALE clocks.
    assign step_tick = (prescale_count == prescale_count_t'(PWM_PRESCALE - 1));

    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            prescale_count <= '0;
        end else if (step_tick) begin
            prescale_count <= '0;
        end else begin
            prescale_count <= prescale_count + 1'b1;
        end
    end

    // Duty position within the period, 0 to PWM_MAX-1.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            duty_count <= '0;
        end else if (step_tick) begin
            if (duty_count == brightness_t'(PWM_MAX - 1)) begin
                duty_count <= '0;
            end else begin
                duty_count <= duty_count + 1'b1;
            end
        end
    end

    // Enable clear means full brightness, the power-on default.
    assign effective = ctrl.brightness_enable ? ctrl.brightness : brightness_t'(PWM_MAX);

    // Zero stays dark, PWM_MAX or more stays lit.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            backlight <= 1'b1;
        end else begin
            backlight <= (duty_count < effective);
        end
    end

endmodule

// File: design/home_button.sv
// **********************************************************************
// Home button synchronizer, debouncer and host-acknowledged latch.
// **********************************************************************
module home_button (
    input  logic          clock_50,
    input  logic          reset_n,
    input  logic          home_button_pin,
    panel_ctrl_if.button  ctrl
);
    import panel_pkg::*;

    logic            sync_0;
    logic            sync_1;
    logic            debounced;
    logic            state_q;
    debounce_state_t db_state;
    debounce_count_t db_count;

    // Button pulls the pin low when pressed.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
        end else begin
            sync_0 <= ~home_button_pin;
            sync_1 <= sync_0;
        end
    end

    // New level is taken after DEBOUNCE_CYCLES differing clocks in a row.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            db_state  <= STABLE;
            db_count  <= '0;
            debounced <= 1'b0;
        end else begin
            case (db_state)
                STABLE: begin
                    if (sync_1 != debounced) begin
                        db_state <= SETTLING;
                        db_count <= debounce_count_t'(1);
                    end
                end
                SETTLING: begin
                    if (sync_1 == debounced) begin
                        // Glitch, back to the old level.
                        db_state <= STABLE;
                    end else if (db_count == debounce_count_t'(DEBOUNCE_CYCLES - 1)) begin
                        db_state  <= STABLE;
                        debounced <= sync_1;
                    end else begin
                        db_count <= db_count + 1'b1;
                    end
                end
                default: db_state <= STABLE;
            endcase
        end
    end

    // Hold until the host acknowledges the current state.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= 1'b0;
        end else if (state_q == ctrl.button_ack) begin
            state_q <= debounced;
        end
    end

    assign ctrl.button_state = state_q;

endmodule

// File: design/panel_top.sv
// **********************************************************************
// Panel top level with the AXI4-Lite slave, backlight and home button.
// **********************************************************************
module panel_top (
    input  logic                  clock_50,
    input  logic                  reset_n,
    // AXI4-Lite slave.
    input  panel_pkg::axil_addr_t s_axil_awaddr,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,
    input  panel_pkg::axil_data_t s_axil_wdata,
    input  panel_pkg::axil_strb_t s_axil_wstrb,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,
    output panel_pkg::axil_resp_t s_axil_bresp,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    input  panel_pkg::axil_addr_t s_axil_araddr,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,
    output panel_pkg::axil_data_t s_axil_rdata,
    output panel_pkg::axil_resp_t s_axil_rresp,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,
    // Board pins.
    input  logic                  home_button_pin,
    output logic                  backlight
);

    panel_ctrl_if ctrl_bus ();

    axil_panel_regs u_regs (
        .clock_50       (clock_50),
        .reset_n        (reset_n),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .ctrl           (ctrl_bus.regs)
    );

    // 200 Hz backlight PWM.
    backlight_pwm u_pwm (
        .clock_50  (clock_50),
        .reset_n   (reset_n),
        .ctrl      (ctrl_bus.pwm),
        .backlight (backlight)
    );

    home_button u_button (
        .clock_50        (clock_50),
        .reset_n         (reset_n),
        .home_button_pin (home_button_pin),
        .ctrl            (ctrl_bus.button)
    );

endmodule

// File: verif/panel_assertions.sv
// **********************************************************************
// Bound checks on the panel top level for AXI4-Lite and the backlight.
// **********************************************************************
module panel_assertions (
    input logic                  clock_50,
    input logic                  reset_n,
    input logic                  s_axil_awready,
    input logic                  s_axil_wready,
    input panel_pkg::axil_resp_t s_axil_bresp,
    input logic                  s_axil_bvalid,
    input logic                  s_axil_bready,
    input logic                  s_axil_arready,
    input panel_pkg::axil_data_t s_axil_rdata,
    input panel_pkg::axil_resp_t s_axil_rresp,
    input logic                  s_axil_rvalid,
    input logic                  s_axil_rready,
    input logic                  backlight,
    input logic                  brightness_enable,
    input panel_pkg::brightness_t brightness
);
    import panel_pkg::*;

    int          failure_count = 0;
    int unsigned stable_cycles;
    int unsigned high_cycles;
    int unsigned rise_gap;
    logic        backlight_q;
    brightness_t brightness_q;
    logic        config_ok;

    // Enabled with a brightness that gives real pulses.
    assign config_ok = brightness_enable && brightness != 0 && brightness < PWM_MAX;

    // Run lengths of the backlight and of an unchanged duty setting.
    always_ff @(posedge clock_50 or negedge reset_n) begin
        if (!reset_n) begin
            stable_cycles <= 0;
            high_cycles   <= 0;
            rise_gap      <= 0;
            backlight_q   <= 1'b1;
            brightness_q  <= '0;
        end else begin
            stable_cycles <= (config_ok && brightness == brightness_q) ? stable_cycles + 1 : 0;
            high_cycles   <= backlight ? high_cycles + 1 : 0;
            rise_gap      <= (backlight && !backlight_q) ? 0 : rise_gap + 1;
            backlight_q   <= backlight;
            brightness_q  <= brightness;
        end
    end

    task automatic report_failure(input string what);
        $error("%s", what);
        failure_count++;
    endtask

    reset_quiet: assert property (@(posedge clock_50) $rose(reset_n) |-> !s_axil_awready
        && !s_axil_wready && !s_axil_bvalid && !s_axil_arready && !s_axil_rvalid)
        else report_failure("AXI ready or valid high right after reset");

    // Disabled or saturated brightness keeps the light on.
    full_on: assert property (@(posedge clock_50) disable iff (!reset_n)
        $past(!brightness_enable || brightness >= PWM_MAX) |-> backlight)
        else report_failure("backlight low with full brightness");

    dark_at_zero: assert property (@(posedge clock_50) disable iff (!reset_n)
        $past(brightness_enable && brightness == 0) |-> !backlight)
        else report_failure("backlight high with brightness zero");

    bresp_held: assert property (@(posedge clock_50) disable iff (!reset_n)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp))
        else report_failure("write response dropped or changed before bready");

    rresp_held: assert property (@(posedge clock_50) disable iff (!reset_n)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rresp)
        && $stable(s_axil_rdata))
        else report_failure("read response dropped or changed before rready");

    write_blocked: assert property (@(posedge clock_50) disable iff (!reset_n)
        s_axil_bvalid |-> !s_axil_awready && !s_axil_wready)
        else report_failure("write accepted while a write response was pending");

    read_blocked: assert property (@(posedge clock_50) disable iff (!reset_n)
        s_axil_rvalid |-> !s_axil_arready)
        else report_failure("read accepted while a read response was pending");

    // Only pulses that ran entirely under one setting are measured.
    pulse_width: assert property (@(posedge clock_50) disable iff (!reset_n)
        $fell(backlight) && stable_cycles > high_cycles + 1
        |-> high_cycles == $past(brightness) * PWM_PRESCALE)
        else report_failure("backlight high pulse has the wrong length");

    pwm_period: assert property (@(posedge clock_50) disable iff (!reset_n)
        $rose(backlight) && stable_cycles > rise_gap + 1
        |-> rise_gap == PWM_MAX * PWM_PRESCALE - 1)
        else report_failure("backlight period has the wrong length");

endmodule

bind panel_top panel_assertions u_assertions (.*,
    .brightness_enable (ctrl_bus.brightness_enable), .brightness (ctrl_bus.brightness));

// File: verif/panel_tb.sv
// **********************************************************************
// Testbench clock, reset, AXI4-Lite tasks and stimulus for the panel top level.
// **********************************************************************
module panel_tb;
    import panel_pkg::*;

    localparam int WAIT_LIMIT    = 32;
    // Synchronizer, debounce and latch latency with some margin.
    localparam int SETTLE_CLOCKS = DEBOUNCE_CYCLES + 16;

    logic       clock_50;
    logic       reset_n;
    axil_addr_t s_axil_awaddr;
    logic       s_axil_awvalid;
    logic       s_axil_awready;
    axil_data_t s_axil_wdata;
    axil_strb_t s_axil_wstrb;
    logic       s_axil_wvalid;
    logic       s_axil_wready;
    axil_resp_t s_axil_bresp;
    logic       s_axil_bvalid;
    logic       s_axil_bready;
    axil_addr_t s_axil_araddr;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    axil_data_t s_axil_rdata;
    axil_resp_t s_axil_rresp;
    logic       s_axil_rvalid;
    logic       s_axil_rready;
    logic       home_button_pin;
    logic       backlight;

    logic [15:0] lfsr_state;
    axil_data_t  ctrl_model;
    int          mismatch_count;
    int          timeout_count;

    panel_top u_dut (.*);

    initial begin
        clock_50 = 1'b0;
        forever #10 clock_50 = ~clock_50;
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_bits(input int width, output axil_data_t value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Strobed bytes replace old ones; only bits 11 to 0 exist.
    function automatic axil_data_t merge_control(input axil_data_t old_value,
                                                 input axil_data_t data, input axil_strb_t strb);
        axil_data_t merged;
        merged = old_value;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = data[8*i +: 8];
            end
        end
        return merged & ((axil_data_t'(1) << (CTRL_ACK_BIT + 1)) - 1);
    endfunction

    function automatic axil_data_t control_word(input int level, input logic ack);
        return axil_data_t'(level) | (axil_data_t'(1) << CTRL_ENABLE_BIT)
            | (axil_data_t'(ack) << CTRL_ACK_BIT);
    endfunction

    task automatic report_and_finish();
        int assert_failures;
        assert_failures = u_dut.u_assertions.failure_count;
        $display("errors: %0d mismatches, %0d assertion failures, %0d timeouts",
                 mismatch_count, assert_failures, timeout_count);
        if (mismatch_count + assert_failures + timeout_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout: %s", what);
    endtask

    task automatic check_value(input string name, input axil_data_t expected,
                               input axil_data_t actual);
        if (expected !== actual) begin
            mismatch_count++;
            $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic wait_clocks(input int count);
        repeat (count) @(negedge clock_50);
    endtask

    task automatic wait_write_response();
        int cycles;
        cycles = 0;
        while (!s_axil_bvalid && cycles < WAIT_LIMIT) begin
            @(negedge clock_50);
            cycles++;
        end
        if (!s_axil_bvalid) begin
            report_timeout("no write response from the DUT");
        end
    endtask

    task automatic wait_read_response();
        int cycles;
        cycles = 0;
        while (!s_axil_rvalid && cycles < WAIT_LIMIT) begin
            @(negedge clock_50);
            cycles++;
        end
        if (!s_axil_rvalid) begin
            report_timeout("no read response from the DUT");
        end
    endtask

    task automatic write_and_check(input string name, input axil_addr_t addr,
                                   input axil_data_t data, input axil_strb_t strb,
                                   input int hold, input axil_resp_t exp_resp);
        @(negedge clock_50);
        s_axil_awaddr  = addr;
        s_axil_awvalid = 1'b1;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_wvalid  = 1'b1;
        wait_write_response();
        // A held response keeps the same write waiting behind it.
        if (hold == 0) begin
            s_axil_awvalid = 1'b0;
            s_axil_wvalid  = 1'b0;
        end
        wait_clocks(hold);
        check_value({name, " bresp"}, axil_data_t'(exp_resp), axil_data_t'(s_axil_bresp));
        s_axil_bready = 1'b1;
        @(negedge clock_50);
        if (hold != 0) begin
            wait_write_response();
            s_axil_awvalid = 1'b0;
            s_axil_wvalid  = 1'b0;
            check_value({name, " repeated bresp"}, axil_data_t'(exp_resp),
                        axil_data_t'(s_axil_bresp));
            @(negedge clock_50);
        end
        s_axil_bready = 1'b0;
        if (addr == CONTROL_ADDR) begin
            ctrl_model = merge_control(ctrl_model, data, strb);
        end
    endtask

    task automatic axil_read(input axil_addr_t addr, input int hold,
                             output axil_data_t data, output axil_resp_t resp);
        @(negedge clock_50);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        wait_read_response();
        // A held response keeps the same read waiting behind it.
        if (hold == 0) begin
            s_axil_arvalid = 1'b0;
        end
        wait_clocks(hold);
        data = s_axil_rdata;
        resp = s_axil_rresp;
        s_axil_rready = 1'b1;
        @(negedge clock_50);
        if (hold != 0) begin
            wait_read_response();
            s_axil_arvalid = 1'b0;
            @(negedge clock_50);
        end
        s_axil_rready = 1'b0;
    endtask

    task automatic expect_read(input string name, input axil_addr_t addr, input int hold,
                               input axil_data_t exp_data, input axil_resp_t exp_resp);
        axil_data_t data;
        axil_resp_t resp;
        axil_read(addr, hold, data, resp);
        check_value({name, " rdata"}, exp_data, data);
        check_value({name, " rresp"}, axil_data_t'(exp_resp), axil_data_t'(resp));
    endtask

    initial begin
        axil_data_t value;
        axil_data_t strobes;
        axil_data_t status;
        axil_resp_t resp;
        int         polls;
        reset_n         = 1'b0;
        s_axil_awaddr   = '0;
        s_axil_awvalid  = 1'b0;
        s_axil_wdata    = '0;
        s_axil_wstrb    = '0;
        s_axil_wvalid   = 1'b0;
        s_axil_bready   = 1'b0;
        s_axil_araddr   = '0;
        s_axil_arvalid  = 1'b0;
        s_axil_rready   = 1'b0;
        home_button_pin = 1'b1;
        lfsr_state      = 16'd59;
        ctrl_model      = '0;
        mismatch_count  = 0;
        timeout_count   = 0;
        wait_clocks(5);
        reset_n = 1'b1;

        expect_read("reset control", CONTROL_ADDR, 0, '0, RESP_OKAY);
        wait_clocks(2 * PWM_PRESCALE);

        repeat (8) begin
            random_bits(32, value);
            random_bits(4, strobes);
            write_and_check("random write", CONTROL_ADDR, value, axil_strb_t'(strobes), 0,
                            RESP_OKAY);
            expect_read("control readback", CONTROL_ADDR, 0, ctrl_model, RESP_OKAY);
        end
        write_and_check("status write", STATUS_ADDR, '1, '1, 0, RESP_SLVERR);
        write_and_check("unmapped write", 8'h10, '1, '1, 0, RESP_SLVERR);
        expect_read("control after bad writes", CONTROL_ADDR, 0, ctrl_model, RESP_OKAY);
        expect_read("unmapped read", 8'h20, 0, '0, RESP_SLVERR);

        // Back-pressure on both response channels.
        random_bits(10, value);
        write_and_check("held write", CONTROL_ADDR, value, '1, 6, RESP_OKAY);
        expect_read("held read", CONTROL_ADDR, 6, ctrl_model, RESP_OKAY);
        write_and_check("held bad write", 8'h0C, '0, '1, 4, RESP_SLVERR);
        expect_read("held bad read", 8'h0C, 4, '0, RESP_SLVERR);

        write_and_check("dark", CONTROL_ADDR, control_word(0, 1'b0), '1, 0, RESP_OKAY);
        wait_clocks(PWM_MAX * PWM_PRESCALE / 10);
        write_and_check("lit", CONTROL_ADDR, control_word(PWM_MAX, 1'b0), '1, 0, RESP_OKAY);
        wait_clocks(PWM_MAX * PWM_PRESCALE / 10);

        // Two and a half periods at brightness 4.
        write_and_check("duty", CONTROL_ADDR, control_word(4, 1'b0), '1, 0, RESP_OKAY);
        wait_clocks(PWM_MAX * PWM_PRESCALE * 5 / 2);

        home_button_pin = 1'b0;
        polls = 0;
        axil_read(STATUS_ADDR, 0, status, resp);
        while (status[0] !== 1'b1 && polls < DEBOUNCE_CYCLES / 8) begin
            wait_clocks(8);
            axil_read(STATUS_ADDR, 0, status, resp);
            polls++;
        end
        if (status[0] !== 1'b1) begin
            report_timeout("status bit never showed the pressed button");
        end
        home_button_pin = 1'b1;
        wait_clocks(SETTLE_CLOCKS);
        expect_read("status before ack", STATUS_ADDR, 0, 32'd1, RESP_OKAY);
        write_and_check("ack set", CONTROL_ADDR, control_word(4, 1'b1), '1, 0, RESP_OKAY);
        expect_read("status after ack", STATUS_ADDR, 0, '0, RESP_OKAY);
        write_and_check("ack clear", CONTROL_ADDR, control_word(4, 1'b0), '1, 0, RESP_OKAY);

        // Too short to pass the debouncer.
        home_button_pin = 1'b0;
        wait_clocks(DEBOUNCE_CYCLES / 2);
        home_button_pin = 1'b1;
        wait_clocks(SETTLE_CLOCKS);
        expect_read("status after glitch", STATUS_ADDR, 0, '0, RESP_OKAY);

        report_and_finish();
    end

endmodule

// File: sources.f
design/panel_pkg.sv
design/panel_ctrl_if.sv
design/axil_panel_regs.sv
design/backlight_pwm.sv
design/home_button.sv
design/panel_top.sv
verif/panel_assertions.sv
verif/panel_tb.sv

// File: run.sh
#!/bin/sh
# Build the panel testbench with Verilator, run it, and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module panel_tb -f sources.f -o panel_sim

./obj_dir/panel_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
grep -q "Result: PASSED" sim.log
